// ==== hdl/vga_timing_pkg.sv ====
package vga_timing_pkg;

  // 640x480 at 60 Hz, one clock per pixel
  // horizontal segments in pixels, line starts at hsync fall
  localparam int h_sync   = 96;
  localparam int h_bp     = 48;
  localparam int h_active = 640;
  localparam int h_fp     = 16;
  localparam int h_total  = h_sync + h_bp + h_active + h_fp;

  // first and one-past-last active pixel of a line
  localparam int h_act_start = h_sync + h_bp;
  localparam int h_act_end   = h_act_start + h_active;

  // vertical segments in lines, frame starts at vsync fall
  localparam int v_sync   = 2;
  localparam int v_bp     = 33;
  localparam int v_active = 480;
  localparam int v_fp     = 10;
  localparam int v_total  = v_sync + v_bp + v_active + v_fp;

  // first and one-past-last active line of a frame
  localparam int v_act_start = v_sync + v_bp;
  localparam int v_act_end   = v_act_start + v_active;

  // counter widths, 800 and 525 both fit in 10 bits
  localparam int h_cnt_w = 10;
  localparam int v_cnt_w = 10;

  // bits per colour channel
  localparam int color_w = 4;

  // test pattern opcodes
  typedef enum logic [1:0] {
    pat_bars  = 2'd0,
    pat_grid  = 2'd1,
    pat_solid = 2'd2,
    pat_off   = 2'd3
  } pattern_e;

endpackage

// ==== hdl/vga_check_pkg.sv ====
package vga_check_pkg;
  import vga_timing_pkg::*;

  // receive-side lock states
  typedef enum logic [1:0] {
    st_wait_low  = 2'd0,
    st_wait_high = 2'd1,
    st_locked    = 2'd2
  } chk_state_e;

  // violation classes, flag bit k is code k+1
  typedef enum logic [2:0] {
    err_none         = 3'd0,
    err_hsync_width  = 3'd1,
    err_hsync_period = 3'd2,
    err_blank_color  = 3'd3,
    err_vsync_width  = 3'd4,
    err_vsync_period = 3'd5
  } err_code_e;

  // one sticky flag per non-zero code
  localparam int n_err_class = 5;

  // status counter width
  localparam int cnt_w = 16;

  // pixel clocks per frame need 19 bits
  localparam int frame_clk_w = $clog2(v_total * h_total + 1);

endpackage

// ==== hdl/vga_if.sv ====
interface vga_if
  import vga_timing_pkg::*;
();

  // colour channels
  logic [color_w-1:0] r;
  logic [color_w-1:0] g;
  logic [color_w-1:0] b;

  // syncs, both active low
  logic hsync;
  logic vsync;

  // pattern stage side
  modport source (output r, g, b, hsync, vsync);

  // checker side
  modport sink (input r, g, b, hsync, vsync);

endinterface

// ==== hdl/vga_sync_gen.sv ====
module vga_sync_gen
  import vga_timing_pkg::*;
(
  input  logic               clk,
  input  logic               arst_n,
  output logic [h_cnt_w-1:0] h_cnt,
  output logic [v_cnt_w-1:0] v_cnt,
  output logic               hsync_n,
  output logic               vsync_n,
  output logic               active,
  output logic [9:0]         x,
  output logic [8:0]         y
);

  logic [h_cnt_w-1:0] h_nxt;
  logic [v_cnt_w-1:0] v_nxt;
  logic               h_vis;
  logic               v_vis;
  logic               hsync_nxt;
  logic               vsync_nxt;
  logic               active_nxt;
  logic [9:0]         x_nxt;
  logic [8:0]         y_nxt;

  // next counter values
  always_comb begin
    h_nxt = h_cnt + 1'b1;
    v_nxt = v_cnt;
    // end of line
    if (h_cnt == h_cnt_w'(h_total - 1)) begin
      h_nxt = '0;
      // end of frame wraps the line counter too
      if (v_cnt == v_cnt_w'(v_total - 1)) begin
        v_nxt = '0;
      end else begin
        v_nxt = v_cnt + 1'b1;
      end
    end
  end

  // decode from the next counts so outputs line up with the counters
  always_comb begin
    // sync is the first segment of line and frame
    hsync_nxt = (h_nxt >= h_sync);
    vsync_nxt = (v_nxt >= v_sync);
    // visible window per axis
    h_vis = (h_nxt >= h_act_start) && (h_nxt < h_act_end);
    v_vis = (v_nxt >= v_act_start) && (v_nxt < v_act_end);
    active_nxt = h_vis && v_vis;
    // coordinates relative to the top left active pixel
    x_nxt = '0;
    y_nxt = '0;
    if (active_nxt) begin
      x_nxt = 10'(h_nxt - h_act_start);
      y_nxt = 9'(v_nxt - v_act_start);
    end
  end

  // counters and decoded levels, all registered
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      // pixel 0 of line 0 is inside both sync pulses
      h_cnt   <= '0;
      v_cnt   <= '0;
      hsync_n <= 1'b0;
      vsync_n <= 1'b0;
      active  <= 1'b0;
      x       <= '0;
      y       <= '0;
    end else begin
      h_cnt   <= h_nxt;
      v_cnt   <= v_nxt;
      hsync_n <= hsync_nxt;
      vsync_n <= vsync_nxt;
      active  <= active_nxt;
      x       <= x_nxt;
      y       <= y_nxt;
    end
  end

endmodule

// ==== hdl/vga_pattern.sv ====
module vga_pattern
  import vga_timing_pkg::*;
(
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 cfg_strobe,
  input  pattern_e             cfg_pattern,
  input  logic [3*color_w-1:0] cfg_color,
  input  logic                 hsync_n,
  input  logic                 vsync_n,
  input  logic                 active,
  input  logic [9:0]           x,
  input  logic [8:0]           y,
  vga_if.source                vga
);

  pattern_e             pattern_q;
  logic [3*color_w-1:0] color_q;
  logic [3*color_w-1:0] rgb;
  logic [2:0]           bar;

  // eight vertical bars, 80 pixels wide
  assign bar = 3'(x / 10'd80);

  // configuration, picked up on the next pixel
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pattern_q <= pat_bars;
      color_q   <= '0;
    end else if (cfg_strobe) begin
      pattern_q <= cfg_pattern;
      color_q   <= cfg_color;
    end
  end

  // colour of the current pixel
  always_comb begin
    rgb = '0;
    if (active) begin
      case (pattern_q)
        // bar index bits drive r, g, b
        pat_bars:  rgb = {{color_w{bar[2]}}, {color_w{bar[1]}}, {color_w{bar[0]}}};
        // white lines every 32 pixels
        pat_grid:  rgb = (x[4:0] == 5'd0 || y[4:0] == 5'd0) ? '1 : '0;
        pat_solid: rgb = color_q;
        default:   rgb = '0;
      endcase
    end
  end

  // one stage for colour and syncs together
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      vga.r     <= '0;
      vga.g     <= '0;
      vga.b     <= '0;
      vga.hsync <= 1'b0;
      vga.vsync <= 1'b0;
    end else begin
      {vga.r, vga.g, vga.b} <= rgb;
      vga.hsync <= hsync_n;
      vga.vsync <= vsync_n;
    end
  end

endmodule

// ==== hdl/vga_timing_checker.sv ====
module vga_timing_checker
  import vga_timing_pkg::*;
  import vga_check_pkg::*;
(
  input  logic      clk,
  input  logic      arst_n,
  vga_if.sink       vga,
  output logic      locked,
  output logic      err_strobe,
  output err_code_e err_code,
  output logic      frame_strobe
);

  chk_state_e             state;
  logic                   hsync_q;
  logic                   vsync_q;
  logic                   h_fall;
  logic                   h_rise;
  logic                   v_fall;
  logic                   v_rise;
  logic [h_cnt_w-1:0]     h_pos;
  logic [h_cnt_w-1:0]     h_pos_cur;
  logic [frame_clk_w-1:0] v_pos;
  logic [frame_clk_w-1:0] v_pos_cur;
  logic                   line_ok;
  logic                   frame_ok;
  logic                   chk;
  logic                   in_blank;
  logic                   color_nz;
  err_code_e              err_nxt;

  assign locked = (state == st_locked);

  // lock sequence, first vsync pulse itself is not measured
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= st_wait_low;
    end else begin
      case (state)
        st_wait_low:  if (!vga.vsync) state <= st_wait_high;
        st_wait_high: if (vga.vsync) state <= st_locked;
        st_locked:    state <= st_locked;
        default:      state <= st_wait_low;
      endcase
    end
  end

  // edges and positions of the current sample
  always_comb begin
    h_fall = hsync_q & ~vga.hsync;
    h_rise = ~hsync_q & vga.hsync;
    v_fall = vsync_q & ~vga.vsync;
    v_rise = ~vsync_q & vga.vsync;
    // position restarts at the falling edge, holds at all ones if sync is lost
    if (h_fall) begin
      h_pos_cur = '0;
    end else if (&h_pos) begin
      h_pos_cur = h_pos;
    end else begin
      h_pos_cur = h_pos + 1'b1;
    end
    // frame position counts pixel clocks
    if (v_fall) begin
      v_pos_cur = '0;
    end else if (&v_pos) begin
      v_pos_cur = v_pos;
    end else begin
      v_pos_cur = v_pos + 1'b1;
    end
    chk      = (state == st_locked);
    in_blank = (h_pos_cur < h_act_start) || (h_pos_cur >= h_act_end);
    color_nz = |{vga.r, vga.g, vga.b};
  end

  // one code per cycle, sync errors take precedence over colour
  always_comb begin
    err_nxt = err_none;
    if (chk && line_ok && h_rise && h_pos_cur != h_cnt_w'(h_sync)) begin
      err_nxt = err_hsync_width;
    end else if (chk && line_ok && h_fall && h_pos != h_cnt_w'(h_total - 1)) begin
      err_nxt = err_hsync_period;
    end else if (chk && frame_ok && v_rise &&
                 v_pos_cur != frame_clk_w'(v_sync * h_total)) begin
      err_nxt = err_vsync_width;
    end else if (chk && frame_ok && v_fall &&
                 v_pos != frame_clk_w'(v_total * h_total - 1)) begin
      err_nxt = err_vsync_period;
    end else if (chk && (line_ok || h_fall) && in_blank && color_nz) begin
      err_nxt = err_blank_color;
    end
  end

  // sample history and measurement counters
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      hsync_q  <= 1'b0;
      vsync_q  <= 1'b0;
      h_pos    <= '0;
      v_pos    <= '0;
      line_ok  <= 1'b0;
      frame_ok <= 1'b0;
    end else begin
      hsync_q <= vga.hsync;
      vsync_q <= vga.vsync;
      h_pos   <= h_pos_cur;
      v_pos   <= v_pos_cur;
      // a reference edge seen while locked arms each check
      if (chk && h_fall) begin
        line_ok <= 1'b1;
      end
      if (chk && v_fall) begin
        frame_ok <= 1'b1;
      end
    end
  end

  // strobes, one cycle after the deciding sample
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      err_strobe   <= 1'b0;
      err_code     <= err_none;
      frame_strobe <= 1'b0;
    end else begin
      err_strobe   <= (err_nxt != err_none);
      err_code     <= err_nxt;
      // the rise that locks is not a counted frame
      frame_strobe <= chk && v_rise;
    end
  end

endmodule

// ==== hdl/vga_check_status.sv ====
module vga_check_status
  import vga_check_pkg::*;
(
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   err_strobe,
  input  err_code_e              err_code,
  input  logic                   frame_strobe,
  input  logic                   clear_strobe,
  output logic [cnt_w-1:0]       err_count,
  output logic [cnt_w-1:0]       frame_count,
  output logic [n_err_class-1:0] err_flags
);

  logic [n_err_class-1:0] err_hit;

  // one-hot of the reported class, code k+1 sets bit k
  always_comb begin
    err_hit = '0;
    for (int k = 0; k < n_err_class; k++) begin
      if (err_strobe && err_code == err_code_e'(k + 1)) begin
        err_hit[k] = 1'b1;
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      err_count   <= '0;
      frame_count <= '0;
      err_flags   <= '0;
    end else if (clear_strobe) begin
      // clear wins over a same-cycle strobe
      err_count   <= '0;
      frame_count <= '0;
      err_flags   <= '0;
    end else begin
      // saturate, never wrap back to zero
      if (err_strobe && !(&err_count)) begin
        err_count <= err_count + 1'b1;
      end
      // frames simply wrap
      if (frame_strobe) begin
        frame_count <= frame_count + 1'b1;
      end
      err_flags <= err_flags | err_hit;
    end
  end

endmodule

// ==== hdl/vga_subsys_top.sv ====
module vga_subsys_top
  import vga_timing_pkg::*;
  import vga_check_pkg::*;
(
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   cfg_strobe,
  input  pattern_e               cfg_pattern,
  input  logic [3*color_w-1:0]   cfg_color,
  input  logic                   clear_strobe,
  input  logic [color_w-1:0]     vga_in_r,
  input  logic [color_w-1:0]     vga_in_g,
  input  logic [color_w-1:0]     vga_in_b,
  input  logic                   vga_in_hsync,
  input  logic                   vga_in_vsync,
  output logic [color_w-1:0]     vga_r,
  output logic [color_w-1:0]     vga_g,
  output logic [color_w-1:0]     vga_b,
  output logic                   vga_hsync,
  output logic                   vga_vsync,
  output logic                   locked,
  output logic [cnt_w-1:0]       err_count,
  output logic [cnt_w-1:0]       frame_count,
  output logic [n_err_class-1:0] err_flags
);

  logic      hsync_n;
  logic      vsync_n;
  logic      active;
  logic [9:0] x;
  logic [8:0] y;
  logic      err_strobe;
  err_code_e err_code;
  logic      frame_strobe;

  // transmit and receive sides of the connector
  vga_if vga_tx ();
  vga_if vga_rx ();

  // raw counters are not needed at this level
  vga_sync_gen u_sync_gen (
    .clk     (clk),
    .arst_n  (arst_n),
    .h_cnt   (),
    .v_cnt   (),
    .hsync_n (hsync_n),
    .vsync_n (vsync_n),
    .active  (active),
    .x       (x),
    .y       (y)
  );

  vga_pattern u_pattern (
    .clk         (clk),
    .arst_n      (arst_n),
    .cfg_strobe  (cfg_strobe),
    .cfg_pattern (cfg_pattern),
    .cfg_color   (cfg_color),
    .hsync_n     (hsync_n),
    .vsync_n     (vsync_n),
    .active      (active),
    .x           (x),
    .y           (y),
    .vga         (vga_tx.source)
  );

  // output pins straight from the pattern register
  assign vga_r     = vga_tx.r;
  assign vga_g     = vga_tx.g;
  assign vga_b     = vga_tx.b;
  assign vga_hsync = vga_tx.hsync;
  assign vga_vsync = vga_tx.vsync;

  // loopback inputs into the receive bundle
  assign vga_rx.r     = vga_in_r;
  assign vga_rx.g     = vga_in_g;
  assign vga_rx.b     = vga_in_b;
  assign vga_rx.hsync = vga_in_hsync;
  assign vga_rx.vsync = vga_in_vsync;

  vga_timing_checker u_checker (
    .clk          (clk),
    .arst_n       (arst_n),
    .vga          (vga_rx.sink),
    .locked       (locked),
    .err_strobe   (err_strobe),
    .err_code     (err_code),
    .frame_strobe (frame_strobe)
  );

  vga_check_status u_status (
    .clk          (clk),
    .arst_n       (arst_n),
    .err_strobe   (err_strobe),
    .err_code     (err_code),
    .frame_strobe (frame_strobe),
    .clear_strobe (clear_strobe),
    .err_count    (err_count),
    .frame_count  (frame_count),
    .err_flags    (err_flags)
  );

endmodule

// ==== dv/vga_subsys_tb.sv ====
module vga_subsys_tb
  import vga_timing_pkg::*;
  import vga_check_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  // run limit of eight frames in pixel clocks
  localparam int max_cycles = 8 * v_total * h_total;

  logic                   clk;
  logic                   arst_n;
  logic                   cfg_strobe;
  pattern_e               cfg_pattern;
  logic [3*color_w-1:0]   cfg_color;
  logic                   clear_strobe;
  logic [color_w-1:0]     vga_in_r;
  logic [color_w-1:0]     vga_in_g;
  logic [color_w-1:0]     vga_in_b;
  logic                   vga_in_hsync;
  logic                   vga_in_vsync;
  logic [color_w-1:0]     vga_r;
  logic [color_w-1:0]     vga_g;
  logic [color_w-1:0]     vga_b;
  logic                   vga_hsync;
  logic                   vga_vsync;
  logic                   locked;
  logic [cnt_w-1:0]       err_count;
  logic [cnt_w-1:0]       frame_count;
  logic [n_err_class-1:0] err_flags;

  // bookkeeping
  int     errors = 0;
  int     n_pass = 0;
  int     n_fail = 0;
  int     cycle = 0;
  integer seed;

  // reference position rebuilt from output sync edges
  int          hpos = 0;
  int          vpos = 0;
  bit          pos_valid = 0;
  logic        prev_hs = 1'b0;
  logic        prev_vs = 1'b0;
  int          hfall_cyc = -1;
  int          vfall_cyc = -1;
  int          vfall_cnt = 0;
  int          vrise_cnt = 0;
  int          lock_cycle = -1;
  pattern_e    exp_pat = pat_bars;
  logic [11:0] exp_color = 12'h000;

  // fault injection on the loopback
  bit   stretch_arm = 0;
  int   stretch_left = 0;
  int   blank_left = 0;
  logic prev_out_hs = 1'b0;

  vga_subsys_top uut (
    .clk          (clk),
    .arst_n       (arst_n),
    .cfg_strobe   (cfg_strobe),
    .cfg_pattern  (cfg_pattern),
    .cfg_color    (cfg_color),
    .clear_strobe (clear_strobe),
    .vga_in_r     (vga_in_r),
    .vga_in_g     (vga_in_g),
    .vga_in_b     (vga_in_b),
    .vga_in_hsync (vga_in_hsync),
    .vga_in_vsync (vga_in_vsync),
    .vga_r        (vga_r),
    .vga_g        (vga_g),
    .vga_b        (vga_b),
    .vga_hsync    (vga_hsync),
    .vga_vsync    (vga_vsync),
    .locked       (locked),
    .err_count    (err_count),
    .frame_count  (frame_count),
    .err_flags    (err_flags)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // colour of one pixel with x and y relative to the active area
  function automatic logic [11:0] expected_pixel(pattern_e pat, logic [11:0] color,
                                                 int x, int y);
    logic [2:0] bar;
    if (x < 0 || x >= h_active || y < 0 || y >= v_active) begin
      return 12'h000;
    end
    // 640 / 8 bars
    bar = 3'(x / 80);
    case (pat)
      pat_bars:  return {{color_w{bar[2]}}, {color_w{bar[1]}}, {color_w{bar[0]}}};
      pat_grid:  return (x % 32 == 0 || y % 32 == 0) ? 12'hfff : 12'h000;
      pat_solid: return color;
      default:   return 12'h000;
    endcase
  endfunction

  task automatic expect_eq(string name, logic [31:0] got, logic [31:0] exp);
    assert (got === exp) else begin
      $display("Error %s exp 0x%0h got 0x%0h", name, exp, got);
      errors++;
    end
  endtask

  task automatic report_test(string name, int err_start);
    if (errors == err_start) begin
      n_pass++;
      $display("test %s: pass", name);
    end else begin
      n_fail++;
      $display("test %s: fail with %0d errors", name, errors - err_start);
    end
  endtask

  // returns on the rising edge right after the output shows a new frame
  task automatic wait_vsync_fall();
    int n;
    n = vfall_cnt;
    do @(posedge clk); while (vfall_cnt == n);
  endtask

  // returns on the rising edge after the output shows pixel h of line l
  task automatic wait_pos(int l, int h);
    do @(posedge clk); while (!(vpos == l && hpos == h));
  endtask

  task automatic load_pattern(pattern_e pat, logic [11:0] color);
    @(posedge clk);
    #5;
    cfg_pattern = pat;
    cfg_color   = color;
    cfg_strobe  = 1'b1;
    @(posedge clk);
    #5;
    cfg_strobe = 1'b0;
    exp_pat    = pat;
    exp_color  = color;
  endtask

  // loopback from the output pins with optional faults
  always @(posedge clk) begin
    #5;
    vga_in_r     = vga_r;
    vga_in_g     = vga_g;
    vga_in_b     = vga_b;
    vga_in_vsync = vga_vsync;
    if (stretch_arm && !prev_out_hs && vga_hsync) begin
      stretch_arm  = 0;
      stretch_left = 4;
    end
    // hold hsync low a few more pixels
    if (stretch_left > 0) begin
      vga_in_hsync = 1'b0;
      stretch_left--;
    end else begin
      vga_in_hsync = vga_hsync;
    end
    // blue in the porch
    if (blank_left > 0) begin
      {vga_in_r, vga_in_g, vga_in_b} = 12'h00f;
      blank_left--;
    end
    prev_out_hs = vga_hsync;
  end

  // position model plus sync timing and pixel compare
  always @(negedge clk) begin : model_compare
    logic        h_fall;
    logic        h_rise;
    logic        v_fall;
    logic        v_rise;
    logic [11:0] exp_rgb;
    if (arst_n) begin
      h_fall = prev_hs & ~vga_hsync;
      h_rise = ~prev_hs & vga_hsync;
      v_fall = prev_vs & ~vga_vsync;
      v_rise = ~prev_vs & vga_vsync;
      if (h_fall) begin
        hpos = 0;
      end else begin
        hpos = hpos + 1;
      end
      if (v_fall) begin
        vpos = 0;
        pos_valid = 1;
        vfall_cnt++;
      end else if (h_fall) begin
        vpos = vpos + 1;
      end
      // line timing
      if (h_rise && hfall_cyc >= 0) begin
        assert (cycle - hfall_cyc == h_sync) else begin
          $display("Error vga_hsync width exp 0x%0h got 0x%0h", h_sync, cycle - hfall_cyc);
          errors++;
        end
      end
      if (h_fall) begin
        if (hfall_cyc >= 0) begin
          assert (cycle - hfall_cyc == h_total) else begin
            $display("Error vga_hsync period exp 0x%0h got 0x%0h", h_total, cycle - hfall_cyc);
            errors++;
          end
        end
        hfall_cyc = cycle;
      end
      // frame timing in pixel clocks
      if (v_rise && vfall_cyc >= 0) begin
        assert (cycle - vfall_cyc == v_sync * h_total) else begin
          $display("Error vga_vsync width exp 0x%0h got 0x%0h", v_sync * h_total,
                   cycle - vfall_cyc);
          errors++;
        end
      end
      if (v_fall) begin
        if (vfall_cyc >= 0) begin
          assert (cycle - vfall_cyc == v_total * h_total) else begin
            $display("Error vga_vsync period exp 0x%0h got 0x%0h", v_total * h_total,
                     cycle - vfall_cyc);
            errors++;
          end
        end
        vfall_cyc = cycle;
      end
      if (locked && lock_cycle < 0) begin
        lock_cycle = cycle;
      end
      // count every output vsync rise
      if (v_rise) begin
        vrise_cnt++;
      end
      if (pos_valid) begin
        exp_rgb = expected_pixel(exp_pat, exp_color, hpos - h_act_start, vpos - v_act_start);
        assert (vga_r === exp_rgb[11:8]) else begin
          $display("Error vga_r exp 0x%h got 0x%h at pixel %0d line %0d",
                   exp_rgb[11:8], vga_r, hpos, vpos);
          errors++;
        end
        assert (vga_g === exp_rgb[7:4]) else begin
          $display("Error vga_g exp 0x%h got 0x%h at pixel %0d line %0d",
                   exp_rgb[7:4], vga_g, hpos, vpos);
          errors++;
        end
        assert (vga_b === exp_rgb[3:0]) else begin
          $display("Error vga_b exp 0x%h got 0x%h at pixel %0d line %0d",
                   exp_rgb[3:0], vga_b, hpos, vpos);
          errors++;
        end
      end
    end
    prev_hs = vga_hsync;
    prev_vs = vga_vsync;
  end

  always @(posedge clk) begin
    cycle++;
    if (cycle >= max_cycles) begin
      $display("Timeout: the run did not finish within %0d clock cycles", max_cycles);
      $display("TEST FAIL");
      $finish;
    end
  end

  initial begin
    int          t0;
    int          seen;
    int          base;
    logic [31:0] rnd;
    seed         = 32'h5836_c89d;
    arst_n       = 1'b0;
    cfg_strobe   = 1'b0;
    cfg_pattern  = pat_bars;
    cfg_color    = '0;
    clear_strobe = 1'b0;
    vga_in_r     = '0;
    vga_in_g     = '0;
    vga_in_b     = '0;
    vga_in_hsync = 1'b0;
    vga_in_vsync = 1'b0;
    repeat (2) @(posedge clk);
    #5;
    arst_n = 1'b1;

    // test 1 checks reset values
    t0 = errors;
    @(negedge clk);
    expect_eq("locked", locked, 0);
    expect_eq("err_count", err_count, 0);
    expect_eq("frame_count", frame_count, 0);
    expect_eq("err_flags", err_flags, 0);
    expect_eq("vga_hsync", vga_hsync, 0);
    expect_eq("vga_vsync", vga_vsync, 0);
    expect_eq("vga_r", vga_r, 0);
    expect_eq("vga_g", vga_g, 0);
    expect_eq("vga_b", vga_b, 0);
    report_test("1 reset state", t0);

    // test 2 runs three clean frames
    t0 = errors;
    repeat (3) wait_vsync_fall();
    // the first rise only locks the checker
    seen = vrise_cnt - 1;
    @(negedge clk);
    assert (lock_cycle >= 0 && lock_cycle < v_total * h_total) else begin
      $display("checker did not lock within the first frame");
      errors++;
    end
    expect_eq("locked", locked, 1);
    expect_eq("frame_count", frame_count, seen);
    expect_eq("err_count", err_count, 0);
    expect_eq("err_flags", err_flags, 0);
    report_test("2 clean loopback", t0);

    // test 3 checks one full frame per pattern loaded in vertical sync
    t0 = errors;
    load_pattern(pat_bars, 12'h000);
    wait_vsync_fall();
    load_pattern(pat_grid, 12'h000);
    wait_vsync_fall();
    rnd = $random(seed);
    load_pattern(pat_solid, rnd[11:0]);
    wait_vsync_fall();
    load_pattern(pat_off, 12'h000);
    wait_vsync_fall();
    report_test("3 patterns", t0);

    // test 4 stretches the line 0 hsync pulse and looks past the next fall
    t0 = errors;
    @(negedge clk);
    base = err_count;
    stretch_arm = 1;
    wait_pos(1, 10);
    @(negedge clk);
    expect_eq("err_count", err_count, base + 1);
    expect_eq("err_flags", err_flags, 1 << (err_hsync_width - 1));
    report_test("4 hsync fault", t0);

    // test 5 puts colour on the first three front porch pixels of line 1
    t0 = errors;
    wait_pos(1, h_act_end - 1);
    blank_left = 3;
    wait_pos(1, h_act_end + 6);
    @(negedge clk);
    expect_eq("err_count", err_count, base + 4);
    expect_eq("err_flags", err_flags,
              (1 << (err_hsync_width - 1)) | (1 << (err_blank_color - 1)));
    report_test("5 blanking fault", t0);

    // test 6 clears ahead of the line 2 vsync rise
    t0 = errors;
    @(posedge clk);
    #5;
    clear_strobe = 1'b1;
    @(posedge clk);
    #5;
    clear_strobe = 1'b0;
    seen = vrise_cnt;
    @(negedge clk);
    expect_eq("err_count", err_count, 0);
    expect_eq("frame_count", frame_count, 0);
    expect_eq("err_flags", err_flags, 0);
    expect_eq("locked", locked, 1);
    do @(posedge clk); while (vrise_cnt == seen);
    // checker strobe then status register
    repeat (3) @(negedge clk);
    expect_eq("frame_count", frame_count, 1);
    expect_eq("err_count", err_count, 0);
    expect_eq("err_flags", err_flags, 0);
    expect_eq("locked", locked, 1);
    report_test("6 clear", t0);

    $display("tests passed: %0d failed: %0d", n_pass, n_fail);
    if (n_fail == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// ==== build.f ====
hdl/vga_timing_pkg.sv
hdl/vga_check_pkg.sv
hdl/vga_if.sv
hdl/vga_sync_gen.sv
hdl/vga_pattern.sv
hdl/vga_timing_checker.sv
hdl/vga_check_status.sv
hdl/vga_subsys_top.sv
dv/vga_subsys_tb.sv
